/* verilog.f */
+incdir+rtl
rtl/noc_flit_pkg.sv
rtl/noc_port_pkg.sv
rtl/noc_switch_if.sv
rtl/noc_input_unit.sv
rtl/noc_rr_arbiter.sv
rtl/noc_switch_control.sv
rtl/noc_crossbar.sv
rtl/noc_router.sv
verif/noc_router_sva.sv
verif/tb_noc_router.sv

/* Makefile */
# Verilator flow for the mesh router testbench

TOP := tb_noc_router

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

# Passes only when the testbench prints its pass line
sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

/* verif/tb_noc_router.sv */
// -------------------------------------------------------------------------
// Router testbench with flit driver, output monitor and scoreboard
// Covers latency, full FIFO, local output fairness and random traffic
// -------------------------------------------------------------------------

`timescale 1ns/1ps

`include "noc_consts.svh"

module tb_noc_router
  import noc_flit_pkg::*;
  import noc_port_pkg::*;
();

  localparam int N       = `NOC_NUM_PORTS;
  localparam int RX      = 1;
  localparam int RY      = 1;
  localparam int TIMEOUT = 2000;
  localparam int SRC_LSB = `NOC_PAYLOAD_W - 3;

  // Wait conditions
  localparam int W_OUT_VALID = 0;
  localparam int W_IN_FULL   = 1;
  localparam int W_LOCAL_CNT = 2;
  localparam int W_ALL_IN    = 3;
  localparam int W_DRAINED   = 4;

  logic          clk         = 1'b0;
  logic          i_reset     = 1'b1;
  logic  [N-1:0] i_in_valid  = '0;
  flit_t [N-1:0] i_in_flit   = '0;
  logic  [N-1:0] o_in_ready;
  logic  [N-1:0] o_out_valid;
  flit_t [N-1:0] o_out_flit;
  logic  [N-1:0] i_out_ready = '1;

  // Traffic setup, changed by the main sequence between clock edges
  int            send_limit [N];
  int            fixed_dst  [N];
  logic  [N-1:0] stall_mask = '0;
  logic          rand_mode  = 1'b0;
  logic          rand_stall = 1'b0;
  logic          fair_on    = 1'b0;

  // Driver and monitor bookkeeping
  integer        seed = 32'h5373_5181;
  int            offered     [N];
  int            in_dst      [N];
  int            accepted    [N];
  int            last_accept [N];
  int            sent_cnt    [N];
  int            recv_cnt    [N];
  int            next_seq    [N][N];
  logic  [N-1:0] in_taken   = '0;
  int            cyc        = 0;
  int            err_count  = 0;
  int            base;
  int            local_src [$];

  noc_router #(.ROUTER_X(RX), .ROUTER_Y(RY)) uut (
    .clk, .i_reset, .i_in_valid, .i_in_flit, .o_in_ready,
    .o_out_valid, .o_out_flit, .i_out_ready
  );

  always #50 clk = ~clk;

  // Destination one hop away toward dst with source and sequence in the payload
  function automatic flit_t build_flit(int dst, int src, int seq);
    coord_t   x;
    coord_t   y;
    payload_t pl;
    x  = coord_t'(RX);
    y  = coord_t'(RY);
    pl = {3'(src), SRC_LSB'(seq)};
    if (dst == int'(PORT_EAST))       x = coord_t'(RX + 1);
    else if (dst == int'(PORT_WEST))  x = coord_t'(RX - 1);
    else if (dst == int'(PORT_NORTH)) y = coord_t'(RY + 1);
    else if (dst == int'(PORT_SOUTH)) y = coord_t'(RY - 1);
    return {x, y, pl};
  endfunction

  // Offers flits up to the limit and holds each one until it is taken
  always @(posedge clk) begin
    int          dst;
    logic [31:0] r1;
    logic [31:0] r2;
    cyc <= cyc + 1;
    if (i_reset) begin
      i_in_valid  <= '0;
      i_out_ready <= '1;
    end else begin
      for (int p = 0; p < N; p++) begin
        if (!i_in_valid[p] || in_taken[p]) begin
          if (offered[p] < send_limit[p] && (!rand_mode || $random(seed) % 2 == 0)) begin
            dst           = rand_mode ? int'({$random(seed)} % N) : fixed_dst[p];
            i_in_valid[p] <= 1'b1;
            i_in_flit[p]  <= build_flit(dst, p, offered[p]);
            in_dst[p]     <= dst;
            offered[p]    <= offered[p] + 1;
          end else begin
            i_in_valid[p] <= 1'b0;
          end
        end
      end
      r1 = $random(seed);
      r2 = $random(seed);
      // Random stalls leave each output ready three cycles in four
      if (rand_stall) i_out_ready <= r1[N-1:0] | r2[N-1:0];
      else            i_out_ready <= ~stall_mask;
    end
  end

  // Handshakes seen here complete at the next rising edge
  always @(negedge clk) begin
    int src;
    int seq;
    in_taken = '0;
    if (!i_reset) begin
      for (int p = 0; p < N; p++) begin
        in_taken[p] = i_in_valid[p] & o_in_ready[p];
        if (in_taken[p]) begin
          accepted[p]++;
          sent_cnt[in_dst[p]]++;
          last_accept[p] = cyc + 1;
        end
        if (o_out_valid[p] && i_out_ready[p]) begin
          src = int'(o_out_flit[p][SRC_LSB +: 3]);
          seq = int'(o_out_flit[p][SRC_LSB-1:0]);
          recv_cnt[p]++;
          if (src >= N) begin
            err_count++;
            $display("Output %0d delivered a flit with no valid source port", p);
          end else begin
            if (seq < next_seq[src][p]) begin
              err_count++;
              $display("ERROR order: out %0d from in %0d expected seq >= %0d, actual %0d",
                       p, src, next_seq[src][p], seq);
            end
            next_seq[src][p] = seq + 1;
          end
          if (fair_on && p == int'(PORT_LOCAL)) local_src.push_back(src);
        end
      end
    end
  end

  function automatic bit cond_met(int kind, int arg);
    int sent;
    int recv;
    bit all_in;
    sent   = 0;
    recv   = 0;
    all_in = 1'b1;
    for (int p = 0; p < N; p++) begin
      sent += sent_cnt[p];
      recv += recv_cnt[p];
      if (accepted[p] != send_limit[p]) all_in = 1'b0;
    end
    case (kind)
      W_OUT_VALID: return o_out_valid[arg];
      W_IN_FULL:   return !o_in_ready[arg];
      W_LOCAL_CNT: return local_src.size() >= arg;
      W_ALL_IN:    return all_in;
      default:     return all_in && sent == recv;
    endcase
  endfunction

  // Checks once per cycle, just after the monitor has run
  task automatic wait_for(int kind, int arg, string what);
    int n;
    n = 0;
    @(negedge clk);
    #1;
    while (!cond_met(kind, arg) && n < TIMEOUT) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (!cond_met(kind, arg)) begin
      err_count++;
      $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
    end
  endtask

  initial begin
    repeat (4) @(posedge clk);
    i_reset <= 1'b0;

    // ------------------------------------------------------------------------
    // Single flit through an idle router
    // ------------------------------------------------------------------------
    wait_for(W_DRAINED, 0, "the idle router");
    fixed_dst[0]  = int'(PORT_EAST);
    send_limit[0] = send_limit[0] + 1;
    wait_for(W_OUT_VALID, int'(PORT_EAST), "the single flit on the east output");
    if (o_out_valid[PORT_EAST] && cyc != last_accept[0] + 1) begin
      err_count++;
      $display("ERROR latency: expected o_out_valid at cycle %0d, actual cycle %0d",
               last_accept[0] + 1, cyc);
    end
    wait_for(W_DRAINED, 0, "the single flit to drain");

    // ------------------------------------------------------------------------
    // Stalled east output fills the west FIFO
    // ------------------------------------------------------------------------
    stall_mask    = N'(1) << PORT_EAST;
    fixed_dst[4]  = int'(PORT_EAST);
    base          = accepted[4];
    send_limit[4] = send_limit[4] + `NOC_FIFO_DEPTH + 2;
    wait_for(W_IN_FULL, int'(PORT_WEST), "o_in_ready to drop on the west input");
    // One flit waits in the east output register and the rest fill the FIFO
    if (accepted[4] - base != `NOC_FIFO_DEPTH + 1) begin
      err_count++;
      $display("ERROR full_fifo: expected %0d flits accepted, actual %0d",
               `NOC_FIFO_DEPTH + 1, accepted[4] - base);
    end

    // North and south compete for the local output
    fair_on       = 1'b1;
    fixed_dst[1]  = int'(PORT_LOCAL);
    fixed_dst[3]  = int'(PORT_LOCAL);
    send_limit[1] = send_limit[1] + 8;
    send_limit[3] = send_limit[3] + 8;
    wait_for(W_LOCAL_CNT, 16, "16 flits on the local output");
    for (int i = 1; i < local_src.size(); i++) begin
      if (local_src[i] == local_src[i-1]) begin
        err_count++;
        $display("ERROR fairness: local flit %0d expected source other than %0d, actual %0d",
                 i, local_src[i-1], local_src[i]);
      end
    end
    fair_on    = 1'b0;
    stall_mask = '0;
    wait_for(W_DRAINED, 0, "the blocked west flits to drain");

    // ------------------------------------------------------------------------
    // Random traffic with random output stalls, then a full drain
    // ------------------------------------------------------------------------
    rand_mode  = 1'b1;
    rand_stall = 1'b1;
    for (int p = 0; p < N; p++) send_limit[p] = send_limit[p] + 40;
    wait_for(W_ALL_IN, 0, "all random flits to be accepted");
    rand_stall = 1'b0;
    wait_for(W_DRAINED, 0, "the random traffic to drain");
    for (int p = 0; p < N; p++) begin
      if (recv_cnt[p] != sent_cnt[p]) begin
        err_count++;
        $display("ERROR flit_count: output %0d expected %0d flits, actual %0d",
                 p, sent_cnt[p], recv_cnt[p]);
      end
    end

    $display("Summary: %0d testbench errors, %0d assertion failures",
             err_count, uut.u_sva.fail_count);
    if (err_count == 0 && uut.u_sva.fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* verif/noc_router_sva.sv */
// -------------------------------------------------------------------------
// Bound assertions for XY routing, output hold under stall and reset state
// -------------------------------------------------------------------------

`timescale 1ns/1ps

`include "noc_consts.svh"

module noc_router_sva
  import noc_flit_pkg::*;
  import noc_port_pkg::*;
#(
  parameter int ROUTER_X = 0,
  parameter int ROUTER_Y = 0
) (
  input logic                            clk,
  input logic                            i_reset,
  input logic       [`NOC_NUM_PORTS-1:0] o_in_ready,
  input logic       [`NOC_NUM_PORTS-1:0] o_out_valid,
  input flit_t      [`NOC_NUM_PORTS-1:0] o_out_flit,
  input logic       [`NOC_NUM_PORTS-1:0] i_out_ready
);

  localparam int N     = `NOC_NUM_PORTS;
  localparam int Y_LSB = `NOC_PAYLOAD_W;
  localparam int X_LSB = `NOC_PAYLOAD_W + `NOC_COORD_W;

  // Number of failed checks, read by the testbench top for its summary
  int fail_count = 0;

  // Output a flit has to take from this router, X first and then Y
  function automatic int xy_port(flit_t f);
    int dx;
    int dy;
    dx = int'(f[X_LSB +: `NOC_COORD_W]);
    dy = int'(f[Y_LSB +: `NOC_COORD_W]);
    if (dx > ROUTER_X) return int'(PORT_EAST);
    if (dx < ROUTER_X) return int'(PORT_WEST);
    if (dy > ROUTER_Y) return int'(PORT_NORTH);
    if (dy < ROUTER_Y) return int'(PORT_SOUTH);
    return int'(PORT_LOCAL);
  endfunction

  for (genvar p = 0; p < N; p++) begin : g_port
    // A valid output flit always belongs on this output
    a_route : assert property (@(posedge clk) disable iff (i_reset)
        o_out_valid[p] |-> xy_port(o_out_flit[p]) == p)
      else begin
        fail_count++;
        $error("output %0d holds a flit that XY routing sends elsewhere", p);
      end

    // A stalled output keeps both its valid and its flit
    a_hold : assert property (@(posedge clk) disable iff (i_reset)
        o_out_valid[p] && !i_out_ready[p] |=> o_out_valid[p] && $stable(o_out_flit[p]))
      else begin
        fail_count++;
        $error("output %0d changed its flit while stalled", p);
      end
  end

  // First cycle out of reset has empty outputs and open inputs
  a_reset_state : assert property (@(posedge clk)
      $fell(i_reset) |-> o_out_valid == '0 && o_in_ready == '1)
    else begin
      fail_count++;
      $error("router left reset with a valid output or a closed input");
    end

endmodule

bind noc_router noc_router_sva #(
  .ROUTER_X (ROUTER_X),
  .ROUTER_Y (ROUTER_Y)
) u_sva (
  .clk         (clk),
  .i_reset     (i_reset),
  .o_in_ready  (o_in_ready),
  .o_out_valid (o_out_valid),
  .o_out_flit  (o_out_flit),
  .i_out_ready (i_out_ready)
);

/* rtl/noc_router.sv */
// -------------------------------------------------------------------------
// Five-port mesh router top with input units, switch control and crossbar
// -------------------------------------------------------------------------

`timescale 1ns/1ps

`include "noc_consts.svh"

module noc_router
  import noc_flit_pkg::*;
  import noc_port_pkg::*;
#(
  parameter int ROUTER_X = 0,
  parameter int ROUTER_Y = 0
) (
  input  logic                            clk,
  input  logic                            i_reset,

  // Upstream side with one valid/ready channel per port
  input  logic       [`NOC_NUM_PORTS-1:0] i_in_valid,
  input  flit_t      [`NOC_NUM_PORTS-1:0] i_in_flit,
  output logic       [`NOC_NUM_PORTS-1:0] o_in_ready,

  // Downstream side with one valid/ready channel per port
  output logic       [`NOC_NUM_PORTS-1:0] o_out_valid,
  output flit_t      [`NOC_NUM_PORTS-1:0] o_out_flit,
  input  logic       [`NOC_NUM_PORTS-1:0] i_out_ready
);

  localparam int N = `NOC_NUM_PORTS;

  // Outputs able to take a flit at the next edge
  port_mask_t         l_out_free;

  // Grant matrix with one row per output
  grant_row_t [N-1:0] l_grant;

  noc_switch_if u_sw_if [N] ();

  // ------------------------------------------------------------------------
  // Input units
  // ------------------------------------------------------------------------

  for (genvar p = 0; p < N; p++) begin : g_in
    noc_input_unit #(
      .ROUTER_X (ROUTER_X),
      .ROUTER_Y (ROUTER_Y),
      .PORT_ID  (p)
    ) u_input_unit (
      .clk,
      .i_reset,
      .i_valid (i_in_valid[p]),
      .i_flit  (i_in_flit[p]),
      .o_ready (o_in_ready[p]),
      .sw      (u_sw_if[p])
    );
  end

  // ------------------------------------------------------------------------
  // Switch allocation and crossbar
  // ------------------------------------------------------------------------

  noc_switch_control u_switch_control (
    .clk,
    .i_reset,
    .i_out_free (l_out_free),
    .o_grant    (l_grant),
    .ports      (u_sw_if)
  );

  noc_crossbar #(
    .ROUTER_X (ROUTER_X),
    .ROUTER_Y (ROUTER_Y)
  ) u_crossbar (
    .clk,
    .i_reset,
    .i_grant    (l_grant),
    .ports      (u_sw_if),
    .o_out_free (l_out_free),
    .o_valid    (o_out_valid),
    .i_ready    (i_out_ready),
    .o_flit     (o_out_flit)
  );

endmodule

/* rtl/noc_crossbar.sv */
// -------------------------------------------------------------------------
// Grant-driven crossbar with a one-entry valid/ready register per output
// -------------------------------------------------------------------------

`timescale 1ns/1ps

`include "noc_consts.svh"

module noc_crossbar
  import noc_flit_pkg::*;
  import noc_port_pkg::*;
#(
  parameter int ROUTER_X = 0,
  parameter int ROUTER_Y = 0
) (
  input  logic                            clk,
  input  logic                            i_reset,
  input  grant_row_t [`NOC_NUM_PORTS-1:0] i_grant,
  noc_switch_if.xbar                      ports [`NOC_NUM_PORTS],
  output port_mask_t                      o_out_free,
  output port_mask_t                      o_valid,
  input  port_mask_t                      i_ready,
  output flit_t      [`NOC_NUM_PORTS-1:0] o_flit
);

  localparam int N        = `NOC_NUM_PORTS;
  localparam int MESH_MAX = (1 << `NOC_COORD_W) - 1;

  // Edge routers have no neighbour on some sides and never free those outputs
  localparam port_mask_t LINK_MASK = {ROUTER_X > 0, ROUTER_Y > 0,
                                      ROUTER_X < MESH_MAX, ROUTER_Y < MESH_MAX,
                                      1'b1};

  flit_t [N-1:0] l_in_flit;

  for (genvar i = 0; i < N; i++) begin : g_link
    assign l_in_flit[i] = ports[i].flit;
  end

  for (genvar o = 0; o < N; o++) begin : g_out
    flit_t l_mux;
    logic  l_load;
    logic  r_valid;
    flit_t r_flit;

    // Grant row is one-hot so an OR of the selected flits is the mux
    always_comb begin
      l_mux = '0;
      for (int i = 0; i < N; i++) begin
        if (i_grant[o][i]) l_mux = l_mux | l_in_flit[i];
      end
    end

    assign l_load = |i_grant[o];

    // A load wins over a take since a free slot is the only way to be granted
    always_ff @(posedge clk) begin
      if (i_reset)         r_valid <= 1'b0;
      else if (l_load)     r_valid <= 1'b1;
      else if (i_ready[o]) r_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
      if (l_load) r_flit <= l_mux;
    end

    // Free when empty or when the held flit leaves at this edge
    assign o_out_free[o] = LINK_MASK[o] & (~r_valid | i_ready[o]);
    assign o_valid[o]    = r_valid;
    assign o_flit[o]     = r_flit;
  end

endmodule

/* rtl/noc_switch_control.sv */
// -------------------------------------------------------------------------
// Switch allocation with one round-robin arbiter per output port
// Requests are masked by output availability and transposed per output
// -------------------------------------------------------------------------

`timescale 1ns/1ps

`include "noc_consts.svh"

module noc_switch_control
  import noc_port_pkg::*;
(
  input  logic                                clk,
  input  logic                                i_reset,
  input  port_mask_t                          i_out_free,
  output grant_row_t [`NOC_NUM_PORTS-1:0]     o_grant,
  noc_switch_if.ctrl                          ports [`NOC_NUM_PORTS]
);

  localparam int N = `NOC_NUM_PORTS;

  // Indexed by input with one bit per wanted output
  port_mask_t [N-1:0] l_in_req;

  // Indexed by output with one bit per requesting input
  grant_row_t [N-1:0] l_out_req;

  // An input is granted when any output picked it
  logic       [N-1:0] l_in_granted;

  // Each link is unpacked into the request and grant vectors
  for (genvar i = 0; i < N; i++) begin : g_link
    assign l_in_req[i]      = ports[i].empty ? '0 : ports[i].req;
    assign ports[i].granted = l_in_granted[i];
  end

  // Transpose and drop every request for an output that cannot take a flit
  always_comb begin
    for (int o = 0; o < N; o++) begin
      for (int i = 0; i < N; i++) begin
        l_out_req[o][i] = l_in_req[i][o] & i_out_free[o];
      end
    end
  end

  // One input requests one output at most so its column has one bit at most
  always_comb begin
    l_in_granted = '0;
    for (int i = 0; i < N; i++) begin
      for (int o = 0; o < N; o++) begin
        l_in_granted[i] = l_in_granted[i] | o_grant[o][i];
      end
    end
  end

  for (genvar o = 0; o < N; o++) begin : g_arb
    noc_rr_arbiter u_arb (
      .clk,
      .i_reset,
      .i_request (l_out_req[o]),
      .o_grant   (o_grant[o])
    );
  end

endmodule

/* rtl/noc_rr_arbiter.sv */
// -------------------------------------------------------------------------
// Round-robin arbiter for one output with a registered priority pointer
// -------------------------------------------------------------------------

`timescale 1ns/1ps

`include "noc_consts.svh"

module noc_rr_arbiter
  import noc_port_pkg::*;
(
  input  logic       clk,
  input  logic       i_reset,
  input  grant_row_t i_request,
  output grant_row_t o_grant
);

  localparam int N     = `NOC_NUM_PORTS;
  localparam int IDX_W = $clog2(N);

  arb_state_e       r_state;
  logic [IDX_W-1:0] r_ptr;
  logic [IDX_W-1:0] r_winner;
  logic [IDX_W-1:0] l_ptr;
  logic [IDX_W-1:0] l_winner;
  logic             l_found;

  // After a grant the priority starts at the input after the last winner
  assign l_ptr = (r_state != ARB_GRANTED)          ? r_ptr :
                 (r_winner == IDX_W'(N - 1))       ? '0    :
                                                     r_winner + 1'b1;

  // First request at or after the pointer wins, wrapping past the top
  always_comb begin
    int idx;
    o_grant  = '0;
    l_winner = l_ptr;
    l_found  = 1'b0;
    for (int off = 0; off < N; off++) begin
      idx = int'(l_ptr) + off;
      if (idx >= N) idx = idx - N;
      if (!l_found && i_request[idx]) begin
        l_found      = 1'b1;
        l_winner     = IDX_W'(idx);
        o_grant[idx] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      r_state  <= ARB_IDLE;
      r_ptr    <= '0;
      r_winner <= '0;
    end else begin
      r_ptr <= l_ptr;
      if (l_found) begin
        r_state  <= ARB_GRANTED;
        r_winner <= l_winner;
      end else begin
        r_state  <= ARB_IDLE;
      end
    end
  end

endmodule

/* rtl/noc_input_unit.sv */
// -------------------------------------------------------------------------
// Input port FIFO with valid/ready acceptance and XY route of the head flit
// -------------------------------------------------------------------------

`timescale 1ns/1ps

`include "noc_consts.svh"

module noc_input_unit
  import noc_flit_pkg::*;
  import noc_port_pkg::*;
#(
  parameter int ROUTER_X = 0,
  parameter int ROUTER_Y = 0,
  parameter int PORT_ID  = 0
) (
  input  logic       clk,
  input  logic       i_reset,
  input  logic       i_valid,
  input  flit_t      i_flit,
  output logic       o_ready,
  noc_switch_if.unit sw
);

  localparam int DEPTH = `NOC_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Coordinates of this router in the mesh
  localparam coord_t MY_X = coord_t'(ROUTER_X);
  localparam coord_t MY_Y = coord_t'(ROUTER_Y);

  // A port number outside the router stops elaboration
  if (PORT_ID < 0 || PORT_ID >= `NOC_NUM_PORTS) begin : g_bad_port_id
    $error("noc_input_unit PORT_ID %0d is not a router port", PORT_ID);
  end

  flit_t            r_mem [DEPTH];
  logic [PTR_W-1:0] r_wr_ptr;
  logic [PTR_W-1:0] r_rd_ptr;
  logic [CNT_W-1:0] r_count;
  logic             l_push;
  logic             l_pop;
  logic             l_empty;
  flit_t            l_head;
  coord_t           l_dx;
  coord_t           l_dy;
  port_e            l_route;

  // Pointer step that wraps at the FIFO depth
  function automatic logic [PTR_W-1:0] ptr_next(logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // ------------------------------------------------------------------------
  // FIFO storage and control
  // ------------------------------------------------------------------------

  assign l_empty = (r_count == '0);
  assign o_ready = (r_count != CNT_W'(DEPTH));
  assign l_push  = i_valid & o_ready;

  // The head flit leaves at the edge after some output grants it
  assign l_pop   = sw.granted;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else begin
      if (l_push) r_wr_ptr <= ptr_next(r_wr_ptr);
      if (l_pop)  r_rd_ptr <= ptr_next(r_rd_ptr);
      // Count moves only when exactly one side is active
      if (l_push && !l_pop)      r_count <= r_count + 1'b1;
      else if (!l_push && l_pop) r_count <= r_count - 1'b1;
    end
  end

  // Flit storage written at the tail pointer
  always_ff @(posedge clk) begin
    if (l_push) r_mem[r_wr_ptr] <= i_flit;
  end

  // ------------------------------------------------------------------------
  // XY route of the head flit
  // ------------------------------------------------------------------------

  assign l_head = r_mem[r_rd_ptr];
  assign l_dx   = flit_dest_x(l_head);
  assign l_dy   = flit_dest_y(l_head);

  // X is resolved first, then Y, and a flit already home goes local
  always_comb begin
    if (l_dx > MY_X)      l_route = PORT_EAST;
    else if (l_dx < MY_X) l_route = PORT_WEST;
    else if (l_dy > MY_Y) l_route = PORT_NORTH;
    else if (l_dy < MY_Y) l_route = PORT_SOUTH;
    else                  l_route = PORT_LOCAL;
  end

  assign sw.flit  = l_head;
  assign sw.empty = l_empty;
  assign sw.req   = l_empty ? '0 : (port_mask_t'(1) << l_route);

endmodule

/* rtl/noc_switch_if.sv */
// -------------------------------------------------------------------------
// Link from one input unit to the switch control and the crossbar
// -------------------------------------------------------------------------

`timescale 1ns/1ps

interface noc_switch_if
  import noc_flit_pkg::*;
  import noc_port_pkg::*;
();

  // One-hot output request of the head flit, zero while the FIFO is empty
  port_mask_t req;

  // Flit at the FIFO head, moved by the crossbar when granted
  flit_t      flit;

  // High for the cycle in which some output grants this input
  logic       granted;

  // FIFO holds no flit
  logic       empty;

  // The input unit owns the head flit and its request
  modport unit (output req, output flit, output empty, input granted);

  // The switch control arbitrates on the request and returns the grant
  modport ctrl (input req, input empty, output granted);

  // The crossbar only needs the head flit
  modport xbar (input flit);

endinterface

/* rtl/noc_port_pkg.sv */
// -------------------------------------------------------------------------
// Switch side types for port numbering, request masks and arbitration
// -------------------------------------------------------------------------

`include "noc_consts.svh"

package noc_port_pkg;

  // Port numbering also gives the bit position in every port mask
  typedef enum logic [2:0] {
    PORT_LOCAL = 3'd0,
    PORT_NORTH = 3'd1,
    PORT_EAST  = 3'd2,
    PORT_SOUTH = 3'd3,
    PORT_WEST  = 3'd4
  } port_e;

  // One bit per output port, used for requests and for the free mask
  typedef logic [`NOC_NUM_PORTS-1:0] port_mask_t;

  // One bit per input port, the inputs that one output grants
  typedef logic [`NOC_NUM_PORTS-1:0] grant_row_t;

  // The arbiter only rotates its pointer after a cycle that granted
  typedef enum logic {
    ARB_IDLE    = 1'b0,
    ARB_GRANTED = 1'b1
  } arb_state_e;

endpackage

/* rtl/noc_flit_pkg.sv */
// -------------------------------------------------------------------------
// Flit format types with the field positions and field access functions
// -------------------------------------------------------------------------

`include "noc_consts.svh"

package noc_flit_pkg;

  typedef logic [`NOC_COORD_W-1:0]   coord_t;
  typedef logic [`NOC_PAYLOAD_W-1:0] payload_t;

  // From the top the flit holds destination x, destination y, then payload
  localparam int FLIT_W     = 2 * `NOC_COORD_W + `NOC_PAYLOAD_W;
  localparam int FLIT_Y_LSB = `NOC_PAYLOAD_W;
  localparam int FLIT_X_LSB = `NOC_PAYLOAD_W + `NOC_COORD_W;

  typedef logic [FLIT_W-1:0] flit_t;

  function automatic coord_t flit_dest_x(flit_t f);
    return f[FLIT_X_LSB +: `NOC_COORD_W];
  endfunction

  function automatic coord_t flit_dest_y(flit_t f);
    return f[FLIT_Y_LSB +: `NOC_COORD_W];
  endfunction

  function automatic flit_t make_flit(coord_t x, coord_t y, payload_t pl);
    return {x, y, pl};
  endfunction

endpackage

/* rtl/noc_consts.svh */
// -------------------------------------------------------------------------
// Router size constants shared by the packages and the RTL
// Port count, mesh coordinate width, payload width and input FIFO depth
// -------------------------------------------------------------------------

`ifndef NOC_CONSTS_SVH
`define NOC_CONSTS_SVH

// Local, north, east, south and west
`define NOC_NUM_PORTS 5

// Width of one mesh coordinate so the mesh is at most 4 by 4
`define NOC_COORD_W 2

// Payload bits carried behind the destination fields
`define NOC_PAYLOAD_W 16

// Entries held by each input FIFO before o_ready drops
`define NOC_FIFO_DEPTH 4

`endif
